// ==== files.f ====
hdl/opman_pkg.sv
hdl/cmd_decode.sv
hdl/operand_fetch.sv
hdl/operand_writeback.sv
hdl/operand_manager.sv
sim/tb_clock.sv
sim/operand_manager_properties.sv
sim/operand_manager_tb.sv

// ==== Bender.yml ====
package:
  name: operand_manager

sources:
  - files:
      - hdl/opman_pkg.sv
      - hdl/cmd_decode.sv
      - hdl/operand_fetch.sv
      - hdl/operand_writeback.sv
      - hdl/operand_manager.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/operand_manager_properties.sv
      - sim/operand_manager_tb.sv

// ==== sim/operand_manager_tb.sv ====
`timescale 1ns/10ps

module operand_manager_tb;
  import opman_pkg::*;

  // worst command: six reads and four writes at 4 cycles each, plus idle and settle
  localparam int WORST_CMD_CYCLES = 120;
  localparam int NUM_CMDS         = 8;
  localparam int MAX_CYCLES       = 2 * WORST_CMD_CYCLES * NUM_CMDS + 80;
  localparam int SETTLE_CYCLES    = 20;

  logic      clk;
  logic      rst;
  logic      start;
  cmd_word_t command_word;
  data_t     cmd_ptr;
  logic      busy;
  data_t     cond;
  data_t     src1;
  data_t     src0;
  logic      operands_valid;
  data_t     dst_value;
  logic      dst_valid;
  addr_t     mem_raddr;
  logic      mem_read;
  data_t     mem_rdata;
  logic      read_dn;
  addr_t     mem_waddr;
  data_t     mem_wdata;
  logic      mem_write;
  logic      write_dn;
  logic      done;

  // memory model state
  data_t       mem [0:65535];
  addr_t       rd_addr;
  addr_t       wr_addr;
  data_t       wr_data;
  int          rd_wait = 0;
  int          wr_wait = 0;
  int          res_wait = 0;
  int          ip_reads = 0;
  logic [15:0] lfsr = 16'd16;

  // bookkeeping
  int cycles = 0;
  int test_num = 0;
  int test_errs = 0;
  int total_errs = 0;
  int failed_tests = 0;
  int checks = 0;

  tb_clock #(.PERIOD_NS(8)) i_tb_clock (.clk);

  operand_manager i_operand_manager (
    .clk, .rst, .start, .command_word, .cmd_ptr, .busy,
    .cond, .src1, .src0, .operands_valid, .dst_value, .dst_valid,
    .mem_raddr, .mem_read, .mem_rdata, .read_dn,
    .mem_waddr, .mem_wdata, .mem_write, .write_dn, .done
  );

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // 1 to 4 cycles, one lfsr step per bit
  function automatic int draw_delay();
    int d;
    d = 1;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      d += int'(lfsr[0]) << b;
    end
    return d;
  endfunction

  function automatic cmd_word_t make_cmd(input reg_num_t c, input reg_num_t s1,
      input reg_num_t s0, input reg_num_t d, input logic [2:0] ptr,
      input adj_t ac, input adj_t a1, input adj_t a0);
    cmd_word_t w;
    w = '0;
    w[COND_NUM_LSB +: REG_W] = c;
    w[S1_NUM_LSB +: REG_W]   = s1;
    w[S0_NUM_LSB +: REG_W]   = s0;
    w[D_NUM_LSB +: REG_W]    = d;
    // pointer bits in fetch order
    w[COND_PTR_BIT] = ptr[0];
    w[S1_PTR_BIT]   = ptr[1];
    w[S0_PTR_BIT]   = ptr[2];
    w[COND_ADJ_LSB +: ADJ_W] = ac;
    w[S1_ADJ_LSB +: ADJ_W]   = a1;
    w[S0_ADJ_LSB +: ADJ_W]   = a0;
    return w;
  endfunction

  task automatic check_eq(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      test_errs++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errs == 0) $display("test %0d %s: ok", test_num, name);
    else $display("test %0d %s: %0d errors", test_num, name, test_errs);
    if (test_errs != 0) failed_tests++;
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // one command end to end, optional second start while busy
  task automatic run_cmd(input cmd_word_t cmd, input data_t ptr, input data_t dval,
      input bit send_ghost, input cmd_word_t ghost);
    reg_num_t r [NUM_SRC];
    logic     p [NUM_SRC];
    adj_t     a [NUM_SRC];
    data_t    raw [NUM_SRC];
    data_t    val [NUM_SRC];
    data_t    exp_regs [16];
    data_t    got [NUM_SRC];
    reg_num_t d;
    int       dones;
    r[0] = cmd[COND_NUM_LSB +: REG_W];
    r[1] = cmd[S1_NUM_LSB +: REG_W];
    r[2] = cmd[S0_NUM_LSB +: REG_W];
    p[0] = cmd[COND_PTR_BIT];
    p[1] = cmd[S1_PTR_BIT];
    p[2] = cmd[S0_PTR_BIT];
    a[0] = cmd[COND_ADJ_LSB +: ADJ_W];
    a[1] = cmd[S1_ADJ_LSB +: ADJ_W];
    a[2] = cmd[S0_ADJ_LSB +: ADJ_W];
    d    = cmd[D_NUM_LSB +: REG_W];
    for (int i = 0; i < 16; i++) exp_regs[i] = mem[i];
    // register 15 is the command pointer, pointers read the low half as address
    for (int i = 0; i < NUM_SRC; i++) begin
      raw[i] = (r[i] == IP_REG) ? ptr : mem[r[i]];
      val[i] = (p[i] && r[i] != IP_REG) ? mem[raw[i][ADDR_W-1:0]] : raw[i];
    end
    // dst first, then adjusted sources it does not cover
    if (d != IP_REG) exp_regs[d] = dval;
    for (int i = 0; i < NUM_SRC; i++) begin
      if ((a[i] == ADJ_INC || a[i] == ADJ_DEC) && r[i] != IP_REG && r[i] != d) begin
        exp_regs[r[i]] = (a[i] == ADJ_INC) ? raw[i] + 32'd1 : raw[i] - 32'd1;
      end
    end
    @(posedge clk);
    command_word <= cmd;
    cmd_ptr      <= ptr;
    dst_value    <= dval;
    start        <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (send_ghost) begin
      repeat (2) @(posedge clk);
      command_word <= ghost;
      cmd_ptr      <= ~ptr;
      start        <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    do @(posedge clk); while (operands_valid !== 1'b1);
    got[0] = cond;
    got[1] = src1;
    got[2] = src0;
    for (int i = 0; i < NUM_SRC; i++) begin
      check_eq($sformatf("operand %0d (reg %0d)", i, r[i]), got[i], val[i]);
    end
    do @(posedge clk); while (done !== 1'b1);
    dones = 1;
    repeat (SETTLE_CYCLES) begin
      @(posedge clk);
      if (done) dones++;
    end
    check_eq("done pulse count", data_t'(dones), 32'd1);
    check_eq("busy after done", data_t'(busy), 32'd0);
    check_eq("reads at register 15", data_t'(ip_reads), 32'd0);
    for (int i = 0; i < 16; i++) begin
      check_eq($sformatf("memory reg %0d", i), mem[i], exp_regs[i]);
    end
  endtask

  // memory with random latency, plus the alu result feed
  always @(posedge clk) begin
    read_dn   <= 1'b0;
    write_dn  <= 1'b0;
    dst_valid <= 1'b0;
    if (mem_read) begin
      rd_addr = mem_raddr;
      rd_wait = draw_delay();
      if (mem_raddr == addr_t'(IP_REG)) ip_reads++;
    end else if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        read_dn   <= 1'b1;
        mem_rdata <= mem[rd_addr];
      end
    end
    if (mem_write) begin
      wr_addr = mem_waddr;
      wr_data = mem_wdata;
      wr_wait = draw_delay();
    end else if (wr_wait > 0) begin
      wr_wait--;
      if (wr_wait == 0) begin
        write_dn     <= 1'b1;
        mem[wr_addr] <= wr_data;
      end
    end
    // result two cycles after the operands
    if (operands_valid) begin
      res_wait = 2;
    end else if (res_wait > 0) begin
      res_wait--;
      if (res_wait == 0) dst_valid <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    rst          = 1'b1;
    start        = 1'b0;
    command_word = '0;
    cmd_ptr      = '0;
    dst_value    = '0;
    dst_valid    = 1'b0;
    mem_rdata    = '0;
    read_dn      = 1'b0;
    write_dn     = 1'b0;
    // upper half is the address, low half a scrambled copy
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {16'(i), 16'(i) ^ 16'hc3a5};
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    check_eq("busy", data_t'(busy), 32'd0);
    check_eq("mem_read", data_t'(mem_read), 32'd0);
    check_eq("mem_write", data_t'(mem_write), 32'd0);
    check_eq("operands_valid", data_t'(operands_valid), 32'd0);
    check_eq("done", data_t'(done), 32'd0);
    finish_test("reset values");

    // dst pointer bit set, must be ignored
    run_cmd(make_cmd(4'd1, 4'd2, 4'd3, 4'd4, 3'b000, 2'b00, 2'b00, 2'b00)
            | (cmd_word_t'(1) << D_PTR_BIT), 32'h0000_1000, 32'hdead_0002, 1'b0, '0);
    finish_test("direct operands");

    run_cmd(make_cmd(4'd15, 4'd5, 4'd15, 4'd6, 3'b000, 2'b00, 2'b00, 2'b00),
            32'h0040_00f0, 32'h1357_0003, 1'b0, '0);
    finish_test("register 15 bypass");

    run_cmd(make_cmd(4'd7, 4'd8, 4'd9, 4'd1, 3'b011, 2'b00, 2'b00, 2'b00),
            32'h0000_2000, 32'h2468_0004, 1'b0, '0);
    finish_test("pointer operands");

    // src0 equals dst, so dst wins
    run_cmd(make_cmd(4'd10, 4'd11, 4'd4, 4'd4, 3'b000, ADJ_INC, ADJ_DEC, ADJ_INC),
            32'h0000_3000, 32'hcafe_0005, 1'b0, '0);
    // dst 15 skips its write, ip source never written back
    run_cmd(make_cmd(4'd15, 4'd12, 4'd13, 4'd15, 3'b000, ADJ_INC, ADJ_INC, 2'b11),
            32'h0000_3100, 32'hbeef_0005, 1'b0, '0);
    finish_test("writeback");

    run_cmd(make_cmd(4'd2, 4'd3, 4'd5, 4'd8, 3'b100, 2'b00, ADJ_DEC, 2'b00),
            32'h0000_4000, 32'h0f0f_0006, 1'b1,
            make_cmd(4'd1, 4'd1, 4'd1, 4'd9, 3'b000, ADJ_INC, 2'b00, 2'b00));
    finish_test("start while busy");

    total_errs += i_operand_manager.i_properties.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_num, failed_tests, checks, total_errs,
             i_operand_manager.i_properties.fail_count);
    if (total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sim/operand_manager_properties.sv ====
`timescale 1ns/10ps

module operand_manager_properties (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic mem_read,
  input logic read_dn,
  input logic mem_write,
  input logic write_dn,
  input logic operands_valid,
  input logic done
);

  // read by the testbench top at the end of the run
  int   fail_count = 0;
  logic rd_pend;
  logic wr_pend;

  // outstanding request tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      if (mem_read) rd_pend <= 1'b1;
      else if (read_dn) rd_pend <= 1'b0;
      if (mem_write) wr_pend <= 1'b1;
      else if (write_dn) wr_pend <= 1'b0;
    end
  end

  a_read_overlap: assert property (@(posedge clk) disable iff (rst) mem_read |-> !rd_pend)
    else begin
      fail_count++;
      $error("mem_read issued while a read was still outstanding");
    end

  a_write_overlap: assert property (@(posedge clk) disable iff (rst) mem_write |-> !wr_pend)
    else begin
      fail_count++;
      $error("mem_write issued while a write was still outstanding");
    end

  // single cycle pulses
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  a_valid_pulse: assert property (
    @(posedge clk) disable iff (rst) operands_valid |=> !operands_valid)
    else begin
      fail_count++;
      $error("operands_valid stayed high for more than one cycle");
    end

  a_read_pulse: assert property (@(posedge clk) disable iff (rst) mem_read |=> !mem_read)
    else begin
      fail_count++;
      $error("mem_read stayed high for more than one cycle");
    end

  // busy rises after an accepted start and holds until done
  a_busy_rise: assert property (@(posedge clk) disable iff (rst) (start && !busy) |=> busy)
    else begin
      fail_count++;
      $error("busy did not rise after an accepted start");
    end

  a_busy_hold: assert property (@(posedge clk) disable iff (rst) (busy && !done) |=> busy)
    else begin
      fail_count++;
      $error("busy dropped before done");
    end

endmodule

bind operand_manager operand_manager_properties i_properties (
  .clk, .rst, .start, .busy, .mem_read, .read_dn,
  .mem_write, .write_dn, .operands_valid, .done
);

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== hdl/operand_manager.sv ====
`timescale 1ns/10ps

module operand_manager (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  opman_pkg::cmd_word_t command_word,
  input  opman_pkg::data_t     cmd_ptr,
  output logic                 busy,
  output opman_pkg::data_t     cond,
  output opman_pkg::data_t     src1,
  output opman_pkg::data_t     src0,
  output logic                 operands_valid,
  input  opman_pkg::data_t     dst_value,
  input  logic                 dst_valid,
  output opman_pkg::addr_t     mem_raddr,
  output logic                 mem_read,
  input  opman_pkg::data_t     mem_rdata,
  input  logic                 read_dn,
  output opman_pkg::addr_t     mem_waddr,
  output opman_pkg::data_t     mem_wdata,
  output logic                 mem_write,
  input  logic                 write_dn,
  output logic                 done
);
  import opman_pkg::*;

  // decode to fetch
  logic               dec_valid;
  reg_num_t           cond_reg;
  reg_num_t           src1_reg;
  reg_num_t           src0_reg;
  logic               cond_ptr;
  logic               src1_ptr;
  logic               src0_ptr;
  data_t              ip_value;
  // decode to writeback
  reg_num_t           dst_reg;
  adj_t               cond_adj;
  adj_t               src1_adj;
  adj_t               src0_adj;
  logic [NUM_SRC-1:0] wr_mask;
  // fetch to writeback
  data_t              cond_raw;
  data_t              src1_raw;
  data_t              src0_raw;

  cmd_decode i_cmd_decode (
    .clk, .rst, .start, .command_word, .cmd_ptr, .done, .busy, .dec_valid,
    .cond_reg, .src1_reg, .src0_reg, .dst_reg,
    .cond_ptr, .src1_ptr, .src0_ptr,
    .cond_adj, .src1_adj, .src0_adj,
    .wr_mask, .ip_value
  );

  operand_fetch i_operand_fetch (
    .clk, .rst, .dec_valid,
    .cond_reg, .src1_reg, .src0_reg,
    .cond_ptr, .src1_ptr, .src0_ptr,
    .ip_value, .mem_raddr, .mem_read, .mem_rdata, .read_dn,
    .cond, .src1, .src0,
    .cond_raw, .src1_raw, .src0_raw,
    .operands_valid
  );

  operand_writeback i_operand_writeback (
    .clk, .rst, .operands_valid, .dst_value, .dst_valid, .dst_reg, .wr_mask,
    .cond_reg, .src1_reg, .src0_reg,
    .cond_adj, .src1_adj, .src0_adj,
    .cond_raw, .src1_raw, .src0_raw,
    .mem_waddr, .mem_wdata, .mem_write, .write_dn, .done
  );

endmodule

// ==== hdl/operand_writeback.sv ====
`timescale 1ns/10ps

module operand_writeback (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          operands_valid,
  input  opman_pkg::data_t              dst_value,
  input  logic                          dst_valid,
  input  opman_pkg::reg_num_t           dst_reg,
  input  logic [opman_pkg::NUM_SRC-1:0] wr_mask,
  input  opman_pkg::reg_num_t           cond_reg,
  input  opman_pkg::reg_num_t           src1_reg,
  input  opman_pkg::reg_num_t           src0_reg,
  input  opman_pkg::adj_t               cond_adj,
  input  opman_pkg::adj_t               src1_adj,
  input  opman_pkg::adj_t               src0_adj,
  input  opman_pkg::data_t              cond_raw,
  input  opman_pkg::data_t              src1_raw,
  input  opman_pkg::data_t              src0_raw,
  output opman_pkg::addr_t              mem_waddr,
  output opman_pkg::data_t              mem_wdata,
  output logic                          mem_write,
  input  logic                          write_dn,
  output logic                          done
);
  import opman_pkg::*;

  wb_state_t          state;
  logic [NUM_SRC-1:0] pend;
  logic [1:0]         sel_idx;
  reg_num_t           sel_reg;
  adj_t               sel_adj;
  data_t              sel_raw;

  // lowest pending source goes first
  always_comb begin
    sel_idx = '0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (pend[i]) sel_idx = 2'(i);
    end
  end

  always_comb begin
    case (sel_idx)
      2'd0: begin
        sel_reg = cond_reg;
        sel_adj = cond_adj;
        sel_raw = cond_raw;
      end
      2'd1: begin
        sel_reg = src1_reg;
        sel_adj = src1_adj;
        sel_raw = src1_raw;
      end
      default: begin
        sel_reg = src0_reg;
        sel_adj = src0_adj;
        sel_raw = src0_raw;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= wb_idle;
      pend      <= '0;
      mem_write <= 1'b0;
    end else begin
      mem_write <= 1'b0;
      case (state)
        wb_idle: begin
          // stale results before this point are dropped
          if (operands_valid) state <= wb_wait_result;
        end
        wb_wait_result: begin
          if (dst_valid) begin
            pend <= wr_mask;
            if (dst_reg != IP_REG) begin
              state <= wb_write_dst;
            end else if (wr_mask != '0) begin
              state <= wb_write_src;
            end else begin
              state <= wb_done;
            end
          end
        end
        wb_write_dst: begin
          mem_write <= 1'b1;
          state     <= wb_wait_dn;
        end
        wb_write_src: begin
          mem_write     <= 1'b1;
          pend[sel_idx] <= 1'b0;
          state         <= wb_wait_dn;
        end
        wb_wait_dn: begin
          if (write_dn) state <= (pend != '0) ? wb_write_src : wb_done;
        end
        default: state <= wb_idle;
      endcase
    end
  end

  // write address and data, held until the next write
  always_ff @(posedge clk) begin
    if (state == wb_wait_result && dst_valid && dst_reg != IP_REG) begin
      mem_waddr <= addr_t'(dst_reg);
      mem_wdata <= dst_value;
    end
    if (state == wb_write_src) begin
      mem_waddr <= addr_t'(sel_reg);
      // mask admits only inc or dec here
      mem_wdata <= (sel_adj == ADJ_INC) ? sel_raw + data_t'(1) : sel_raw - data_t'(1);
    end
  end

  // done is the single cycle spent in wb_done
  assign done = (state == wb_done);

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/10ps

module operand_fetch (
  input  logic                clk,
  input  logic                rst,
  input  logic                dec_valid,
  input  opman_pkg::reg_num_t cond_reg,
  input  opman_pkg::reg_num_t src1_reg,
  input  opman_pkg::reg_num_t src0_reg,
  input  logic                cond_ptr,
  input  logic                src1_ptr,
  input  logic                src0_ptr,
  input  opman_pkg::data_t    ip_value,
  output opman_pkg::addr_t    mem_raddr,
  output logic                mem_read,
  input  opman_pkg::data_t    mem_rdata,
  input  logic                read_dn,
  output opman_pkg::data_t    cond,
  output opman_pkg::data_t    src1,
  output opman_pkg::data_t    src0,
  output opman_pkg::data_t    cond_raw,
  output opman_pkg::data_t    src1_raw,
  output opman_pkg::data_t    src0_raw,
  output logic                operands_valid
);
  import opman_pkg::*;

  fetch_state_t state;
  logic [1:0]   idx;
  reg_num_t     cur_reg;
  logic         cur_ptr;
  data_t        val_q [NUM_SRC];
  data_t        raw_q [NUM_SRC];

  // descriptor of the operand being fetched
  always_comb begin
    case (idx)
      2'd0: begin
        cur_reg = cond_reg;
        cur_ptr = cond_ptr;
      end
      2'd1: begin
        cur_reg = src1_reg;
        cur_ptr = src1_ptr;
      end
      default: begin
        cur_reg = src0_reg;
        cur_ptr = src0_ptr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= fetch_idle;
      idx            <= '0;
      mem_read       <= 1'b0;
      operands_valid <= 1'b0;
    end else begin
      // request and valid are single pulses
      mem_read       <= 1'b0;
      operands_valid <= 1'b0;
      case (state)
        fetch_idle: begin
          if (dec_valid) begin
            idx   <= '0;
            state <= fetch_reg;
          end
        end
        fetch_reg: begin
          // ip register bypasses the bus
          if (cur_reg == IP_REG) begin
            state <= fetch_next;
          end else begin
            mem_read <= 1'b1;
            state    <= fetch_reg_wait;
          end
        end
        fetch_reg_wait: begin
          if (read_dn) begin
            if (cur_ptr) begin
              mem_read <= 1'b1;
              state    <= fetch_ptr_wait;
            end else begin
              state <= fetch_next;
            end
          end
        end
        fetch_ptr_wait: begin
          if (read_dn) begin
            state <= fetch_next;
          end
        end
        fetch_next: begin
          if (idx == 2'(NUM_SRC - 1)) begin
            operands_valid <= 1'b1;
            state          <= fetch_idle;
          end else begin
            idx   <= idx + 2'd1;
            state <= fetch_reg;
          end
        end
        default: state <= fetch_idle;
      endcase
    end
  end

  // address and operand capture
  always_ff @(posedge clk) begin
    if (state == fetch_reg) begin
      if (cur_reg == IP_REG) begin
        raw_q[idx] <= ip_value;
        val_q[idx] <= ip_value;
      end else begin
        mem_raddr <= addr_t'(cur_reg);
      end
    end
    if (state == fetch_reg_wait && read_dn) begin
      raw_q[idx] <= mem_rdata;
      val_q[idx] <= mem_rdata;
      // pointer target is the low half of the register
      if (cur_ptr) begin
        mem_raddr <= mem_rdata[ADDR_W-1:0];
      end
    end
    if (state == fetch_ptr_wait && read_dn) begin
      val_q[idx] <= mem_rdata;
    end
  end

  assign cond     = val_q[0];
  assign src1     = val_q[1];
  assign src0     = val_q[2];
  assign cond_raw = raw_q[0];
  assign src1_raw = raw_q[1];
  assign src0_raw = raw_q[2];

endmodule

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/10ps

module cmd_decode (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  opman_pkg::cmd_word_t            command_word,
  input  opman_pkg::data_t                cmd_ptr,
  input  logic                            done,
  output logic                            busy,
  output logic                            dec_valid,
  output opman_pkg::reg_num_t             cond_reg,
  output opman_pkg::reg_num_t             src1_reg,
  output opman_pkg::reg_num_t             src0_reg,
  output opman_pkg::reg_num_t             dst_reg,
  output logic                            cond_ptr,
  output logic                            src1_ptr,
  output logic                            src0_ptr,
  output opman_pkg::adj_t                 cond_adj,
  output opman_pkg::adj_t                 src1_adj,
  output opman_pkg::adj_t                 src0_adj,
  output logic [opman_pkg::NUM_SRC-1:0]   wr_mask,
  output opman_pkg::data_t                ip_value
);
  import opman_pkg::*;

  cmd_word_t cmd_q;
  logic      accept;

  // source gets written back only if it adjusts, is not ip, and dst does not overwrite it
  function automatic logic wb_needed(reg_num_t rnum, adj_t adj, reg_num_t dnum);
    logic adjusting;
    adjusting = (adj == ADJ_INC) || (adj == ADJ_DEC);
    return adjusting && (rnum != IP_REG) && (rnum != dnum);
  endfunction

  // one command in flight
  assign accept = start && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // command and pointer held for the whole sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q    <= command_word;
      ip_value <= cmd_ptr;
    end
  end

  // field split
  assign cond_reg = cmd_q[COND_NUM_LSB +: REG_W];
  assign src1_reg = cmd_q[S1_NUM_LSB +: REG_W];
  assign src0_reg = cmd_q[S0_NUM_LSB +: REG_W];
  assign dst_reg  = cmd_q[D_NUM_LSB +: REG_W];
  assign cond_ptr = cmd_q[COND_PTR_BIT];
  assign src1_ptr = cmd_q[S1_PTR_BIT];
  assign src0_ptr = cmd_q[S0_PTR_BIT];
  assign cond_adj = cmd_q[COND_ADJ_LSB +: ADJ_W];
  assign src1_adj = cmd_q[S1_ADJ_LSB +: ADJ_W];
  assign src0_adj = cmd_q[S0_ADJ_LSB +: ADJ_W];

  // writeback mask in fetch order
  assign wr_mask[0] = wb_needed(cond_reg, cond_adj, dst_reg);
  assign wr_mask[1] = wb_needed(src1_reg, src1_adj, dst_reg);
  assign wr_mask[2] = wb_needed(src0_reg, src0_adj, dst_reg);

endmodule

// ==== hdl/opman_pkg.sv ====
package opman_pkg;

  // basic widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int REG_W  = 4;
  localparam int ADJ_W  = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [REG_W-1:0]  reg_num_t;
  typedef logic [ADJ_W-1:0]  adj_t;
  typedef logic [31:0]       cmd_word_t;

  // register number fields
  localparam int S1_NUM_LSB   = 0;
  localparam int S0_NUM_LSB   = 4;
  localparam int D_NUM_LSB    = 8;
  localparam int COND_NUM_LSB = 12;

  // pointer bits, dst pointer not honoured
  localparam int S1_PTR_BIT   = 16;
  localparam int S0_PTR_BIT   = 17;
  localparam int D_PTR_BIT    = 18;
  localparam int COND_PTR_BIT = 19;

  // adjust code fields, dst adjust not honoured
  localparam int S1_ADJ_LSB   = 20;
  localparam int S0_ADJ_LSB   = 22;
  localparam int D_ADJ_LSB    = 24;
  localparam int COND_ADJ_LSB = 26;

  // post-increment / post-decrement codes
  localparam adj_t ADJ_INC = 2'b01;
  localparam adj_t ADJ_DEC = 2'b10;

  // register 15 reads back as the command pointer
  localparam reg_num_t IP_REG = 4'd15;

  // sources indexed 0 cond, 1 src1, 2 src0
  localparam int NUM_SRC = 3;

  typedef enum logic [2:0] {
    fetch_idle, fetch_reg, fetch_reg_wait, fetch_ptr_wait, fetch_next
  } fetch_state_t;

  typedef enum logic [2:0] {
    wb_idle, wb_wait_result, wb_write_dst, wb_write_src, wb_wait_dn, wb_done
  } wb_state_t;

endpackage
